// File: mb_cfg.svh
`ifndef MB_CFG_SVH
`define MB_CFG_SVH

// ==============================
// store geometry
// ==============================

// log2 of product store depth, 64 entries
`define MB_DEPTH_LOG 6

// ==============================
// datapath widths
// ==============================

// unsigned operand width, four nibbles
`define MB_OP_WIDTH 16
`define MB_PROD_WIDTH 32

// register stages from accepting edge to product valid
`define MB_PIPE_STAGES 8

`endif

// File: mult_pkg.sv
`include "mb_cfg.svh"

package mult_pkg;

    // ==============================
    // operand views
    // ==============================

    // nibble view of an operand, n0 is least significant
    typedef struct packed {
        logic [3:0] n3;
        logic [3:0] n2;
        logic [3:0] n1;
        logic [3:0] n0;
    } nibbles_t;

    // one operand word, read whole or as nibbles
    typedef union packed {
        logic [`MB_OP_WIDTH-1:0] word;
        nibbles_t                nib;
    } operand_u;

    // ==============================
    // result types
    // ==============================

    // 4x4 partial product
    typedef logic [7:0] pp_t;

    // full product, also the store word
    typedef logic [`MB_PROD_WIDTH-1:0] prod_t;

endpackage

// File: buffer_pkg.sv
`include "mb_cfg.svh"

package buffer_pkg;

    // ==============================
    // controller
    // ==============================

    // fill: taking operands
    // flush: input closed, products still in flight
    // full: store holds a whole block
    // drain: block streaming out
    typedef enum logic [1:0] {
        FILL  = 2'd0,
        FLUSH = 2'd1,
        FULL  = 2'd2,
        DRAIN = 2'd3
    } fill_state_e;

    // ==============================
    // store addressing
    // ==============================

    // one entry per product of a block
    typedef logic [`MB_DEPTH_LOG-1:0] addr_t;

endpackage

// File: nibble_mult_pipe.sv
`timescale 1ns/1ns
`include "mb_cfg.svh"

module nibble_mult_pipe (
    input  logic               clk,
    input  logic               rst,
    input  logic               in_valid,
    input  mult_pkg::operand_u a,
    input  mult_pkg::operand_u b,
    output logic               out_valid,
    output mult_pkg::prod_t    product
);

    // nibble pick by index, struct fields are not indexable
    function automatic logic [3:0] nib_sel(input mult_pkg::operand_u x, input int unsigned idx);
        logic [3:0] n;
        case (idx)
            0:       n = x.nib.n0;
            1:       n = x.nib.n1;
            2:       n = x.nib.n2;
            default: n = x.nib.n3;
        endcase
        return n;
    endfunction

    // ==============================
    // valid sidecar
    // ==============================

    // one bit per register stage, moves with the data
    logic [`MB_PIPE_STAGES-1:0] vld;

    always_ff @(posedge clk) begin
        if (rst) begin
            vld <= '0;
        end else begin
            vld <= {vld[`MB_PIPE_STAGES-2:0], in_valid};
        end
    end

    assign out_valid = vld[`MB_PIPE_STAGES-1];

    // ==============================
    // stage 1: operand register
    // ==============================

    mult_pkg::operand_u a_s0, b_s0;
    mult_pkg::operand_u a_s1, b_s1;

    // whole words here, no decode yet
    always_ff @(posedge clk) begin
        a_s0.word <= a.word;
        b_s0.word <= b.word;
    end

    // ==============================
    // stage 2: rows 0 and 1
    // ==============================

    // pp_lo[i][j] = a nibble i times b nibble j
    mult_pkg::pp_t pp_lo_s1 [2][4];

    always_ff @(posedge clk) begin
        // upper a nibbles still needed next stage
        a_s1 <= a_s0;
        b_s1 <= b_s0;
        for (int i = 0; i < 2; i++) begin
            for (int j = 0; j < 4; j++) begin
                pp_lo_s1[i][j] <= mult_pkg::pp_t'(nib_sel(a_s0, i))
                                * mult_pkg::pp_t'(nib_sel(b_s0, j));
            end
        end
    end

    // ==============================
    // stage 3: rows 2 and 3
    // ==============================

    // all sixteen partials aligned here
    mult_pkg::pp_t pp [4][4];

    always_ff @(posedge clk) begin
        for (int i = 0; i < 2; i++) begin
            for (int j = 0; j < 4; j++) begin
                pp[i][j] <= pp_lo_s1[i][j];
            end
        end
        for (int i = 2; i < 4; i++) begin
            for (int j = 0; j < 4; j++) begin
                pp[i][j] <= mult_pkg::pp_t'(nib_sel(a_s1, i))
                          * mult_pkg::pp_t'(nib_sel(b_s1, j));
            end
        end
    end

    // ==============================
    // stage 4: weighted partials
    // ==============================

    // weight of p_ij is 2^(4*(i+j))
    mult_pkg::prod_t spp [16];

    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 4; j++) begin
                spp[i*4+j] <= mult_pkg::prod_t'(pp[i][j]) << (4 * (i + j));
            end
        end
    end

    // ==============================
    // stages 5-8: adder tree
    // ==============================

    mult_pkg::prod_t lvl1 [8];
    mult_pkg::prod_t lvl2 [4];
    mult_pkg::prod_t lvl3 [2];
    mult_pkg::prod_t sum_q;

    // 16 -> 8
    always_ff @(posedge clk) begin
        for (int k = 0; k < 8; k++) begin
            lvl1[k] <= spp[2*k] + spp[2*k+1];
        end
    end

    // 8 -> 4
    always_ff @(posedge clk) begin
        for (int k = 0; k < 4; k++) begin
            lvl2[k] <= lvl1[2*k] + lvl1[2*k+1];
        end
    end

    // 4 -> 2
    always_ff @(posedge clk) begin
        for (int k = 0; k < 2; k++) begin
            lvl3[k] <= lvl2[2*k] + lvl2[2*k+1];
        end
    end

    // final sum, no overflow since 16x16 fits in 32
    always_ff @(posedge clk) begin
        sum_q <= lvl3[0] + lvl3[1];
    end

    assign product = sum_q;

endmodule

// File: product_store.sv
`timescale 1ns/1ns
`include "mb_cfg.svh"

module product_store (
    input  logic              clk,
    input  logic              wr_en,
    input  buffer_pkg::addr_t wr_addr,
    input  mult_pkg::prod_t   wr_data,
    input  logic              rd_en,
    input  buffer_pkg::addr_t rd_addr,
    output mult_pkg::prod_t   rd_data
);

    // ==============================
    // storage
    // ==============================

    // one block of products
    mult_pkg::prod_t mem [2**`MB_DEPTH_LOG];

    // write port
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // read port, output holds between reads
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

// File: fill_ctrl.sv
`timescale 1ns/1ns
`include "mb_cfg.svh"

module fill_ctrl (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    in_valid,
    output logic                    in_ready,
    input  logic [`MB_OP_WIDTH-1:0] in_a,
    input  logic [`MB_OP_WIDTH-1:0] in_b,
    output logic                    mul_in_valid,
    output mult_pkg::operand_u      mul_a,
    output mult_pkg::operand_u      mul_b,
    input  logic                    mul_out_valid,
    input  mult_pkg::prod_t         mul_product,
    output logic                    wr_en,
    output buffer_pkg::addr_t       wr_addr,
    output mult_pkg::prod_t         wr_data,
    input  logic                    drain_start,
    output logic                    drain_go,
    input  logic                    drain_done,
    output logic                    block_full
);

    buffer_pkg::fill_state_e state;
    buffer_pkg::addr_t       acc_cnt;
    buffer_pkg::addr_t       wr_cnt;
    logic                    accept;

    // ==============================
    // input side
    // ==============================

    // only FILL takes operands, so at most one block is accepted
    assign in_ready     = (state == buffer_pkg::FILL);
    assign accept       = in_valid & in_ready;
    assign mul_in_valid = accept;

    // word view going into the multiplier
    always_comb begin
        mul_a.word = in_a;
        mul_b.word = in_b;
    end

    // ==============================
    // write side
    // ==============================

    // every product goes straight to the store
    assign wr_en      = mul_out_valid;
    assign wr_addr    = wr_cnt;
    assign wr_data    = mul_product;
    assign block_full = (state == buffer_pkg::FULL);

    // ==============================
    // sequencing
    // ==============================

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= buffer_pkg::FILL;
            acc_cnt  <= '0;
            wr_cnt   <= '0;
            drain_go <= 1'b0;
        end else begin
            drain_go <= 1'b0;
            // counters wrap to 0 on the last item of a block
            if (accept) begin
                acc_cnt <= acc_cnt + 1'b1;
            end
            if (mul_out_valid) begin
                wr_cnt <= wr_cnt + 1'b1;
            end
            case (state)
                buffer_pkg::FILL: begin
                    // 64th acceptance closes the input
                    if (accept && acc_cnt == '1) begin
                        state <= buffer_pkg::FLUSH;
                    end
                end
                buffer_pkg::FLUSH: begin
                    // wait out the pipeline, 64th write fills the store
                    if (mul_out_valid && wr_cnt == '1) begin
                        state <= buffer_pkg::FULL;
                    end
                end
                buffer_pkg::FULL: begin
                    if (drain_start) begin
                        state    <= buffer_pkg::DRAIN;
                        drain_go <= 1'b1;
                    end
                end
                buffer_pkg::DRAIN: begin
                    if (drain_done) begin
                        state   <= buffer_pkg::FILL;
                        acc_cnt <= '0;
                        wr_cnt  <= '0;
                    end
                end
                default: state <= buffer_pkg::FILL;
            endcase
        end
    end

endmodule

// File: block_drain.sv
`timescale 1ns/1ns
`include "mb_cfg.svh"

module block_drain (
    input  logic              clk,
    input  logic              rst,
    input  logic              drain_go,
    output logic              drain_done,
    output logic              rd_en,
    output buffer_pkg::addr_t rd_addr,
    input  mult_pkg::prod_t   rd_data,
    output logic              out_valid,
    input  logic              out_ready,
    output mult_pkg::prod_t   out_data
);

    // ==============================
    // read issue
    // ==============================

    logic              rd_active;
    buffer_pkg::addr_t rd_cnt;
    // read issued last cycle, rd_data valid now
    logic              rd_pend;
    // skid entries plus the read in flight
    logic [1:0]        occ;

    // skid FIFO state
    mult_pkg::prod_t   fifo [2];
    logic              wr_ptr;
    logic              rd_ptr;
    logic [1:0]        count;

    logic              head_valid;
    logic              xfer;
    logic              push;
    logic              pop;
    buffer_pkg::addr_t out_cnt;

    assign occ     = count + {1'b0, rd_pend};
    // credit check, never more than two words owed
    assign rd_en   = rd_active & (occ < 2'd2);
    assign rd_addr = rd_cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_active <= 1'b0;
            rd_cnt    <= '0;
            rd_pend   <= 1'b0;
        end else begin
            rd_pend <= rd_en;
            if (drain_go) begin
                rd_active <= 1'b1;
                rd_cnt    <= '0;
            end else if (rd_en) begin
                rd_cnt <= rd_cnt + 1'b1;
                // last address issued
                if (rd_cnt == '1) begin
                    rd_active <= 1'b0;
                end
            end
        end
    end

    // ==============================
    // skid buffer and output
    // ==============================

    // empty FIFO passes fresh read data straight through
    assign head_valid = (count != 2'd0);
    assign out_valid  = head_valid | rd_pend;
    assign out_data   = head_valid ? fifo[rd_ptr] : rd_data;
    assign xfer       = out_valid & out_ready;

    // fresh data is stored unless it went out this cycle
    assign push = rd_pend & ~(xfer & ~head_valid);
    assign pop  = xfer & head_valid;

    // payload only
    always_ff @(posedge clk) begin
        if (push) begin
            fifo[wr_ptr] <= rd_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= 2'd0;
        end else begin
            if (push) begin
                wr_ptr <= ~wr_ptr;
            end
            if (pop) begin
                rd_ptr <= ~rd_ptr;
            end
            count <= count + {1'b0, push} - {1'b0, pop};
        end
    end

    // ==============================
    // block end
    // ==============================

    always_ff @(posedge clk) begin
        if (rst) begin
            out_cnt    <= '0;
            drain_done <= 1'b0;
        end else begin
            drain_done <= xfer && (out_cnt == '1);
            if (xfer) begin
                out_cnt <= out_cnt + 1'b1;
            end
        end
    end

endmodule

// File: mult_buffer_top.sv
`timescale 1ns/1ns
`include "mb_cfg.svh"

module mult_buffer_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      in_valid,
    output logic                      in_ready,
    input  logic [`MB_OP_WIDTH-1:0]   in_a,
    input  logic [`MB_OP_WIDTH-1:0]   in_b,
    output logic                      out_valid,
    input  logic                      out_ready,
    output logic [`MB_PROD_WIDTH-1:0] out_data,
    input  logic                      drain_start,
    output logic                      block_full
);

    // ==============================
    // internal nets
    // ==============================

    // controller to multiplier
    logic               mul_in_valid;
    mult_pkg::operand_u mul_a;
    mult_pkg::operand_u mul_b;
    logic               mul_out_valid;
    mult_pkg::prod_t    mul_product;

    // store ports
    logic               wr_en;
    buffer_pkg::addr_t  wr_addr;
    mult_pkg::prod_t    wr_data;
    logic               rd_en;
    buffer_pkg::addr_t  rd_addr;
    mult_pkg::prod_t    rd_data;

    // controller to drain unit
    logic               drain_go;
    logic               drain_done;

    // ==============================
    // instances
    // ==============================

    fill_ctrl i_fill_ctrl (
        .clk           (clk),
        .rst           (rst),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .in_a          (in_a),
        .in_b          (in_b),
        .mul_in_valid  (mul_in_valid),
        .mul_a         (mul_a),
        .mul_b         (mul_b),
        .mul_out_valid (mul_out_valid),
        .mul_product   (mul_product),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .drain_start   (drain_start),
        .drain_go      (drain_go),
        .drain_done    (drain_done),
        .block_full    (block_full)
    );

    nibble_mult_pipe i_mult (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (mul_in_valid),
        .a         (mul_a),
        .b         (mul_b),
        .out_valid (mul_out_valid),
        .product   (mul_product)
    );

    product_store i_store (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    block_drain i_drain (
        .clk        (clk),
        .rst        (rst),
        .drain_go   (drain_go),
        .drain_done (drain_done),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_data   (out_data)
    );

endmodule

// File: tb_mult_buffer.sv
`timescale 1ns/1ns
`include "mb_cfg.svh"

module tb_mult_buffer;

    localparam int NUM_TESTS = 5;
    localparam int BLOCK     = 2**`MB_DEPTH_LOG;
    localparam int FILL_TMO  = 2000;
    localparam int FLUSH_TMO = 4 * `MB_PIPE_STAGES;
    localparam int DRAIN_TMO = 4000;
    localparam int REFILL_TMO = 16;
    // cycles of silence expected after an early drain request
    localparam int QUIET_WIN = 20;

    logic                      clk;
    logic                      rst;
    logic                      in_valid;
    logic                      in_ready;
    logic [`MB_OP_WIDTH-1:0]   in_a;
    logic [`MB_OP_WIDTH-1:0]   in_b;
    logic                      out_valid;
    logic                      out_ready;
    logic [`MB_PROD_WIDTH-1:0] out_data;
    logic                      drain_start;
    logic                      block_full;

    // ==============================
    // test table
    // ==============================

    // one block per row in table order
    string test_name   [NUM_TESTS] = '{"corner_full_rate", "early_drain_req",
                                       "random_gaps_bp", "heavy_backpressure",
                                       "second_corner_block"};
    // percent of fill cycles with in_valid low
    int    gap_pct     [NUM_TESTS] = '{0, 0, 40, 15, 0};
    // percent of drain cycles with out_ready high
    int    ready_pct   [NUM_TESTS] = '{100, 100, 50, 20, 70};
    // 0 for corner pairs or 1 for random operands
    int    use_random  [NUM_TESTS] = '{0, 1, 1, 1, 0};
    // drain_start pulse in the middle of the fill
    int    early_drain [NUM_TESTS] = '{0, 1, 0, 0, 0};
    // rotation of the corner list so a later corner block differs
    int    corner_ofs  [NUM_TESTS] = '{0, 0, 0, 0, 7};

    // golden model of plain products in acceptance order
    logic [`MB_PROD_WIDTH-1:0] exp_q [$];

    string cur_name;
    int    cur_test;
    int    errors;
    int    test_errors;
    bit    aborted;

    mult_buffer_top i_dut (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .in_a        (in_a),
        .in_b        (in_b),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_data    (out_data),
        .drain_start (drain_start),
        .block_full  (block_full)
    );

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ==============================
    // helpers
    // ==============================

    function automatic bit random_hit(input int pct);
        return int'($urandom_range(99)) < pct;
    endfunction

    // corner operand pairs packed as {a, b}
    function automatic logic [31:0] corner_pair(input int idx);
        logic [15:0] x;
        x = 16'(idx * 291 + 5);
        case (idx % 16)
            0:       return {16'h0000, x};
            1:       return {x, 16'h0000};
            2:       return {16'hFFFF, 16'hFFFF};
            3:       return {16'h0001, 16'hFFFF};
            4:       return {16'hFFFF, 16'h0001};
            // nibble boundaries
            5:       return {16'h000F, 16'h000F};
            6:       return {16'h00F0, 16'h0F00};
            7:       return {16'hF000, 16'hF000};
            8:       return {16'h0010, 16'h0010};
            9:       return {16'h1000, 16'h0FFF};
            10:      return {16'h8000, 16'h8000};
            11:      return {16'h7FFF, 16'h7FFF};
            12:      return {16'h0F0F, 16'hF0F0};
            13:      return {16'h1111, 16'hEEEE};
            14:      return {16'h00FF, 16'hFF00};
            default: return {16'hFFF0, 16'h000F};
        endcase
    endfunction

    task automatic note_error(input string msg);
        $display("ERROR %0s: %0s", cur_name, msg);
        errors++;
        test_errors++;
    endtask

    // later tests are skipped since the DUT state is unknown
    task automatic note_timeout(input string msg);
        $display("TIMEOUT %0s: %0s", cur_name, msg);
        errors++;
        test_errors++;
        aborted = 1'b1;
    endtask

    // ==============================
    // block phases
    // ==============================

    task automatic fill_block(input int t);
        int          n_acc;
        int          cycles;
        int          quiet;
        bit          pulsed;
        logic [31:0] ops;
        n_acc  = 0;
        cycles = 0;
        pulsed = 1'b0;
        while (n_acc < BLOCK && !aborted) begin
            @(negedge clk);
            // nothing leaves while the store fills
            if (out_valid || block_full) begin
                note_error("out_valid or block_full high during fill");
            end
            if (early_drain[t] != 0 && n_acc == BLOCK / 2 && !pulsed) begin
                pulsed      = 1'b1;
                in_valid    = 1'b0;
                drain_start = 1'b1;
                quiet       = 0;
                while (quiet < QUIET_WIN) begin
                    @(negedge clk);
                    drain_start = 1'b0;
                    if (out_valid) begin
                        note_error("out_valid after drain_start before block_full");
                    end
                    quiet++;
                end
            end
            if (random_hit(gap_pct[t])) begin
                in_valid = 1'b0;
            end else begin
                if (use_random[t] != 0) begin
                    ops = {16'($urandom()), 16'($urandom())};
                end else begin
                    ops = corner_pair(n_acc + corner_ofs[t]);
                end
                in_valid = 1'b1;
                in_a     = ops[31:16];
                in_b     = ops[15:0];
            end
            // in_ready follows the state and holds until the next edge
            if (in_valid && in_ready) begin
                exp_q.push_back(32'(in_a) * 32'(in_b));
                n_acc++;
            end
            cycles++;
            if (cycles > FILL_TMO) begin
                note_timeout("fill did not take a whole block");
            end
        end
    endtask

    task automatic wait_for_full();
        int cycles;
        cycles = 0;
        // keep offering a pair to show the input stays closed
        while (!block_full && !aborted) begin
            @(negedge clk);
            in_valid = 1'b1;
            in_a     = 16'hDEAD;
            in_b     = 16'hBEEF;
            if (in_ready) begin
                note_error("pair accepted beyond one block");
            end
            if (out_valid) begin
                note_error("out_valid before block_full");
            end
            cycles++;
            if (cycles > FLUSH_TMO) begin
                note_timeout("block_full never rose");
            end
        end
        in_valid = 1'b0;
    endtask

    task automatic drain_block(input int t);
        int          cycles;
        int          n_out;
        bit          held;
        logic [31:0] held_data;
        logic [31:0] exp;
        cycles    = 0;
        n_out     = 0;
        held      = 1'b0;
        held_data = '0;
        if (aborted) begin
            return;
        end
        @(negedge clk);
        drain_start = 1'b1;
        while (n_out < BLOCK && !aborted) begin
            @(negedge clk);
            drain_start = 1'b0;
            // a stalled word stays put
            if (held && (!out_valid || out_data !== held_data)) begin
                note_error("out_data changed while stalled");
            end
            out_ready = random_hit(ready_pct[t]);
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    note_error("output word with no expected product");
                end else begin
                    exp = exp_q.pop_front();
                    if (out_data !== exp) begin
                        $display("MISMATCH %0s: expected %08h, actual %08h",
                                 cur_name, exp, out_data);
                        errors++;
                        test_errors++;
                    end
                end
                n_out++;
            end
            held      = out_valid && !out_ready;
            held_data = out_data;
            cycles++;
            if (cycles > DRAIN_TMO) begin
                note_timeout("drain did not deliver a whole block");
            end
        end
        // last word transfers on the coming edge
        @(negedge clk);
        out_ready = 1'b0;
    endtask

    task automatic wait_for_refill();
        int cycles;
        cycles = 0;
        while (!(in_ready && !block_full) && !aborted) begin
            @(negedge clk);
            if (out_valid) begin
                note_error("extra output word after the block end");
            end
            cycles++;
            if (cycles > REFILL_TMO) begin
                note_timeout("in_ready did not return after the drain");
            end
        end
        if (!aborted && exp_q.size() != 0) begin
            note_error("expected products never came out");
        end
        exp_q.delete();
    endtask

    // ==============================
    // main sequence
    // ==============================

    initial begin
        int passed;
        int run;
        passed      = 0;
        run         = 0;
        errors      = 0;
        aborted     = 1'b0;
        void'($urandom(99));
        rst         = 1'b1;
        in_valid    = 1'b0;
        in_a        = '0;
        in_b        = '0;
        out_ready   = 1'b0;
        drain_start = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // idle state right after reset
        cur_name    = "reset_state";
        test_errors = 0;
        if (!in_ready || out_valid || block_full) begin
            note_error("wrong status after reset");
        end
        run++;
        if (test_errors == 0) begin
            passed++;
        end
        $display("test %0s: %0s, %0d errors", cur_name,
                 (test_errors == 0) ? "ok" : "failed", test_errors);

        for (cur_test = 0; cur_test < NUM_TESTS && !aborted; cur_test++) begin
            cur_name    = test_name[cur_test];
            test_errors = 0;
            fill_block(cur_test);
            wait_for_full();
            drain_block(cur_test);
            wait_for_refill();
            run++;
            if (test_errors == 0) begin
                passed++;
            end
            $display("test %0s: %0s, %0d errors", cur_name,
                     (test_errors == 0) ? "ok" : "failed", test_errors);
        end

        $display("tests run %0d, passed %0d, failed %0d, errors %0d",
                 run, passed, run - passed, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+.
mult_pkg.sv
buffer_pkg.sv
nibble_mult_pipe.sv
product_store.sv
fill_ctrl.sv
block_drain.sv
mult_buffer_top.sv
tb_mult_buffer.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_mult_buffer -f files.f

out="$(./obj_dir/Vtb_mult_buffer)"
echo "$out"

if echo "$out" | grep -qx "RESULT: PASS"; then
    exit 0
else
    exit 1
fi
